// ==== Bender.yml ====
package:
  name: cmo_handler

sources:
  - source/cmo_pkg.sv
  - source/dir_port_if.sv
  - source/cache_dir.sv
  - source/set_range_tracker.sv
  - source/cmo_sequencer.sv
  - source/flush_req_queue.sv
  - source/cmo_handler_top.sv
  - target: simulation
    files:
      - verification/tb_cmo_handler.sv

// ==== flist.f ====
source/cmo_pkg.sv
source/dir_port_if.sv
source/cache_dir.sv
source/set_range_tracker.sv
source/cmo_sequencer.sv
source/flush_req_queue.sv
source/cmo_handler_top.sv
verification/tb_cmo_handler.sv

// ==== source/cache_dir.sv ====
/* Cache directory: valid, dirty and tag per set and way, with line lookup,
   registered entry check and a clocked update port */
module cache_dir (
    input logic     clk_i,
    input logic     rst_ni,
    dir_port_if.dir dir
);

    logic [cmo_pkg::WAYS-1:0] valid_q [cmo_pkg::NSETS];
    logic [cmo_pkg::WAYS-1:0] dirty_q [cmo_pkg::NSETS];
    cmo_pkg::tag_t            tag_q   [cmo_pkg::NSETS][cmo_pkg::WAYS];

    // Tag compare in every way of the looked-up set
    always_comb begin
        dir.hit_way = '0;
        for (int w = 0; w < cmo_pkg::WAYS; w++) begin
            dir.hit_way[w] = dir.lookup_en && valid_q[dir.lookup_set][w]
                             && (tag_q[dir.lookup_set][w] == dir.lookup_tag);
        end
        dir.hit_dirty = |(dir.hit_way & dirty_q[dir.lookup_set]);
    end

    // State bits and entry flags
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < cmo_pkg::NSETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            dir.entry_valid <= 1'b0;
            dir.entry_dirty <= 1'b0;
        end else begin
            if (dir.updt_en) begin
                for (int w = 0; w < cmo_pkg::WAYS; w++) begin
                    if (dir.updt_way[w]) begin
                        valid_q[dir.updt_set][w] <= dir.updt_valid;
                        dirty_q[dir.updt_set][w] <= dir.updt_dirty;
                    end
                end
            end
            // Check way is one-hot, so a masked reduce picks the entry
            if (dir.check_en) begin
                dir.entry_valid <= |(valid_q[dir.check_set] & dir.check_way);
                dir.entry_dirty <= |(dirty_q[dir.check_set] & dir.check_way);
            end
        end
    end

    // Tag array and checked tag
    always_ff @(posedge clk_i) begin
        if (dir.updt_en) begin
            for (int w = 0; w < cmo_pkg::WAYS; w++) begin
                if (dir.updt_way[w]) begin
                    tag_q[dir.updt_set][w] <= dir.updt_tag;
                end
            end
        end
        if (dir.check_en) begin
            for (int w = 0; w < cmo_pkg::WAYS; w++) begin
                if (dir.check_way[w]) begin
                    dir.entry_tag <= tag_q[dir.check_set][w];
                end
            end
        end
    end

endmodule

// ==== source/cmo_handler_top.sv ====
/* Top level of the maintenance handler: directory, range tracker,
   sequencer and flush queue behind plain request, response and flush ports */
module cmo_handler_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_valid_i,
    input  cmo_pkg::cmo_op_e  req_op_i,
    input  cmo_pkg::addr_t    req_addr_i,
    input  cmo_pkg::way_vec_t req_way_i,
    input  logic              req_dirty_i,
    input  cmo_pkg::tid_t     req_tid_i,
    output logic              req_ready_o,
    input  logic              rsp_ready_i,
    output logic              rsp_valid_o,
    output cmo_pkg::tid_t     rsp_tid_o,
    output logic              rsp_hit_o,
    output logic              rsp_dirty_o,
    input  logic              flush_ready_i,
    output logic              flush_valid_o,
    output cmo_pkg::nline_t   flush_nline_o,
    output cmo_pkg::way_vec_t flush_way_o
);

    cmo_pkg::set_t     valid_min;
    cmo_pkg::set_t     valid_max;
    logic              valid_any;
    cmo_pkg::set_t     dirty_min;
    cmo_pkg::set_t     dirty_max;
    logic              dirty_any;
    logic              clear_valid;
    logic              clear_dirty;
    logic              push;
    cmo_pkg::nline_t   push_nline;
    cmo_pkg::way_vec_t push_way;
    logic              q_not_full;
    logic              q_empty;

    dir_port_if u_dir_if ();

    cache_dir u_cache_dir (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .dir    (u_dir_if.dir)
    );

    set_range_tracker u_tracker (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .mon           (u_dir_if.mon),
        .clear_valid_i (clear_valid),
        .clear_dirty_i (clear_dirty),
        .valid_min_o   (valid_min),
        .valid_max_o   (valid_max),
        .valid_any_o   (valid_any),
        .dirty_min_o   (dirty_min),
        .dirty_max_o   (dirty_max),
        .dirty_any_o   (dirty_any)
    );

    cmo_sequencer u_sequencer (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_valid_i   (req_valid_i),
        .req_op_i      (req_op_i),
        .req_addr_i    (req_addr_i),
        .req_way_i     (req_way_i),
        .req_dirty_i   (req_dirty_i),
        .req_tid_i     (req_tid_i),
        .req_ready_o   (req_ready_o),
        .dir           (u_dir_if.seq),
        .valid_min_i   (valid_min),
        .valid_max_i   (valid_max),
        .valid_any_i   (valid_any),
        .dirty_min_i   (dirty_min),
        .dirty_max_i   (dirty_max),
        .dirty_any_i   (dirty_any),
        .clear_valid_o (clear_valid),
        .clear_dirty_o (clear_dirty),
        .push_o        (push),
        .push_nline_o  (push_nline),
        .push_way_o    (push_way),
        .q_not_full_i  (q_not_full),
        .q_empty_i     (q_empty),
        .rsp_ready_i   (rsp_ready_i),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_tid_o     (rsp_tid_o),
        .rsp_hit_o     (rsp_hit_o),
        .rsp_dirty_o   (rsp_dirty_o)
    );

    flush_req_queue u_flush_q (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (push),
        .push_nline_i (push_nline),
        .push_way_i   (push_way),
        .not_full_o   (q_not_full),
        .empty_o      (q_empty),
        .pop_valid_o  (flush_valid_o),
        .pop_ready_i  (flush_ready_i),
        .pop_nline_o  (flush_nline_o),
        .pop_way_o    (flush_way_o)
    );

endmodule

// ==== source/cmo_pkg.sv ====
/* Geometry constants, address field types, operation and sequencer state
   enums for the cache-maintenance handler */
package cmo_pkg;

    // Directory geometry
    localparam int unsigned ADDR_W        = 16;
    localparam int unsigned OFFSET_W      = 4;
    localparam int unsigned SET_W         = 3;
    localparam int unsigned TAG_W         = 9;
    localparam int unsigned NLINE_W       = TAG_W + SET_W;
    localparam int unsigned WAYS          = 4;
    localparam int unsigned NSETS         = 1 << SET_W;
    localparam int unsigned TID_W         = 4;
    localparam int unsigned FLUSH_Q_DEPTH = 4;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [SET_W-1:0]   set_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [NLINE_W-1:0] nline_t;
    typedef logic [WAYS-1:0]    way_vec_t;
    typedef logic [TID_W-1:0]   tid_t;

    // Request opcodes
    typedef enum logic [2:0] {
        CMO_FILL,
        CMO_PROBE,
        CMO_INVAL_NLINE,
        CMO_INVAL_ALL,
        CMO_FLUSH_ALL,
        CMO_FLUSH_INVAL_ALL
    } cmo_op_e;

    // Sequencer FSM
    typedef enum logic [2:0] {
        IDLE,
        CHECK_NLINE,
        UPDATE_NLINE,
        INVAL_SET,
        FLUSH_FIRST,
        FLUSH_NEXT,
        FLUSH_DRAIN,
        RESPOND
    } cmo_state_e;

endpackage

// ==== source/cmo_sequencer.sv ====
/* Maintenance operation FSM: request acceptance, line fill, probe and
   invalidation, set walks, write-back pushes and the response register */
module cmo_sequencer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_valid_i,
    input  cmo_pkg::cmo_op_e  req_op_i,
    input  cmo_pkg::addr_t    req_addr_i,
    input  cmo_pkg::way_vec_t req_way_i,
    input  logic              req_dirty_i,
    input  cmo_pkg::tid_t     req_tid_i,
    output logic              req_ready_o,
    dir_port_if.seq           dir,
    input  cmo_pkg::set_t     valid_min_i,
    input  cmo_pkg::set_t     valid_max_i,
    input  logic              valid_any_i,
    input  cmo_pkg::set_t     dirty_min_i,
    input  cmo_pkg::set_t     dirty_max_i,
    input  logic              dirty_any_i,
    output logic              clear_valid_o,
    output logic              clear_dirty_o,
    output logic              push_o,
    output cmo_pkg::nline_t   push_nline_o,
    output cmo_pkg::way_vec_t push_way_o,
    input  logic              q_not_full_i,
    input  logic              q_empty_i,
    input  logic              rsp_ready_i,
    output logic              rsp_valid_o,
    output cmo_pkg::tid_t     rsp_tid_o,
    output logic              rsp_hit_o,
    output logic              rsp_dirty_o
);

    cmo_pkg::cmo_state_e state_q, state_d;
    cmo_pkg::cmo_op_e    op_q, op_d;
    cmo_pkg::set_t       set_q, set_d;
    cmo_pkg::way_vec_t   way_q, way_d;
    cmo_pkg::tag_t       tag_q, tag_d;
    logic                dirty_q, dirty_d;
    cmo_pkg::tid_t       tid_q, tid_d;
    logic                pend_q, pend_d;
    cmo_pkg::set_t       pend_set_q, pend_set_d;
    cmo_pkg::way_vec_t   pend_way_q, pend_way_d;
    logic                rsp_hit_q, rsp_hit_d;
    logic                rsp_dirty_q, rsp_dirty_d;

    cmo_pkg::set_t req_set;
    cmo_pkg::tag_t req_tag;
    cmo_pkg::set_t set_max;
    logic          flush_inval;
    logic          set_last;
    logic          way_last;

    assign req_set     = req_addr_i[cmo_pkg::OFFSET_W +: cmo_pkg::SET_W];
    assign req_tag     = req_addr_i[cmo_pkg::OFFSET_W + cmo_pkg::SET_W +: cmo_pkg::TAG_W];
    assign flush_inval = (op_q == cmo_pkg::CMO_FLUSH_INVAL_ALL);
    assign set_max     = (op_q == cmo_pkg::CMO_FLUSH_ALL) ? dirty_max_i : valid_max_i;
    assign set_last    = (set_q == set_max);
    assign way_last    = way_q[cmo_pkg::WAYS-1];

    always_comb begin
        state_d     = state_q;
        op_d        = op_q;
        set_d       = set_q;
        way_d       = way_q;
        tag_d       = tag_q;
        dirty_d     = dirty_q;
        tid_d       = tid_q;
        pend_d      = pend_q;
        pend_set_d  = pend_set_q;
        pend_way_d  = pend_way_q;
        rsp_hit_d   = rsp_hit_q;
        rsp_dirty_d = rsp_dirty_q;

        req_ready_o    = 1'b0;
        clear_valid_o  = 1'b0;
        clear_dirty_o  = 1'b0;
        push_o         = 1'b0;
        dir.lookup_en  = 1'b0;
        dir.lookup_set = set_q;
        dir.lookup_tag = tag_q;
        dir.check_en   = 1'b0;
        dir.check_set  = set_q;
        dir.check_way  = way_q;
        dir.updt_en    = 1'b0;
        dir.updt_set   = set_q;
        dir.updt_way   = way_q;
        dir.updt_valid = 1'b0;
        dir.updt_dirty = 1'b0;
        dir.updt_tag   = tag_q;

        // Update of the entry checked last cycle, only set during flush walks
        if (pend_q) begin
            dir.updt_en    = dir.entry_valid && (dir.entry_dirty || flush_inval);
            dir.updt_set   = pend_set_q;
            dir.updt_way   = pend_way_q;
            dir.updt_valid = !flush_inval;
            dir.updt_tag   = dir.entry_tag;
            push_o         = dir.entry_valid && dir.entry_dirty;
            pend_d         = 1'b0;
        end

        case (state_q)
            cmo_pkg::IDLE: begin
                req_ready_o    = 1'b1;
                dir.lookup_en  = req_valid_i;
                dir.lookup_set = req_set;
                dir.lookup_tag = req_tag;
                if (req_valid_i) begin
                    op_d        = req_op_i;
                    set_d       = req_set;
                    tag_d       = req_tag;
                    way_d       = req_way_i;
                    dirty_d     = req_dirty_i;
                    tid_d       = req_tid_i;
                    pend_d      = 1'b0;
                    rsp_hit_d   = 1'b0;
                    rsp_dirty_d = 1'b0;
                    // Empty ranges answer straight away
                    state_d     = cmo_pkg::RESPOND;
                    case (req_op_i)
                        cmo_pkg::CMO_FILL: state_d = cmo_pkg::UPDATE_NLINE;
                        cmo_pkg::CMO_PROBE: begin
                            rsp_hit_d   = |dir.hit_way;
                            rsp_dirty_d = dir.hit_dirty;
                        end
                        cmo_pkg::CMO_INVAL_NLINE: state_d = cmo_pkg::CHECK_NLINE;
                        cmo_pkg::CMO_INVAL_ALL: begin
                            if (valid_any_i) begin
                                set_d   = valid_min_i;
                                state_d = cmo_pkg::INVAL_SET;
                            end
                        end
                        cmo_pkg::CMO_FLUSH_ALL: begin
                            if (dirty_any_i) begin
                                set_d   = dirty_min_i;
                                way_d   = cmo_pkg::way_vec_t'(1);
                                state_d = cmo_pkg::FLUSH_FIRST;
                            end
                        end
                        cmo_pkg::CMO_FLUSH_INVAL_ALL: begin
                            if (valid_any_i) begin
                                set_d   = valid_min_i;
                                way_d   = cmo_pkg::way_vec_t'(1);
                                state_d = cmo_pkg::FLUSH_FIRST;
                            end
                        end
                        default: ;
                    endcase
                end
            end
            cmo_pkg::UPDATE_NLINE: begin
                dir.updt_en    = 1'b1;
                dir.updt_valid = 1'b1;
                dir.updt_dirty = dirty_q;
                state_d        = cmo_pkg::RESPOND;
            end
            cmo_pkg::CHECK_NLINE: begin
                dir.lookup_en = 1'b1;
                dir.updt_en   = |dir.hit_way;
                dir.updt_way  = dir.hit_way;
                state_d       = cmo_pkg::RESPOND;
            end
            cmo_pkg::INVAL_SET: begin
                dir.updt_en  = 1'b1;
                dir.updt_way = '1;
                set_d        = set_q + 1'b1;
                if (set_last) begin
                    clear_valid_o = 1'b1;
                    state_d       = cmo_pkg::RESPOND;
                end
            end
            cmo_pkg::FLUSH_FIRST, cmo_pkg::FLUSH_NEXT: begin
                // A push this cycle leaves no guaranteed room for the next check
                if (q_not_full_i && !push_o) begin
                    dir.check_en = 1'b1;
                    pend_d       = 1'b1;
                    pend_set_d   = set_q;
                    pend_way_d   = way_q;
                    way_d        = {way_q[cmo_pkg::WAYS-2:0], way_q[cmo_pkg::WAYS-1]};
                    if (way_last) begin
                        set_d = set_q + 1'b1;
                    end
                    state_d = (way_last && set_last) ? cmo_pkg::FLUSH_DRAIN
                                                     : cmo_pkg::FLUSH_NEXT;
                end
            end
            cmo_pkg::FLUSH_DRAIN: begin
                if (!pend_q && q_empty_i) begin
                    clear_dirty_o = 1'b1;
                    clear_valid_o = flush_inval;
                    state_d       = cmo_pkg::RESPOND;
                end
            end
            cmo_pkg::RESPOND: begin
                if (rsp_ready_i) begin
                    state_d = cmo_pkg::IDLE;
                end
            end
            default: state_d = cmo_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= cmo_pkg::IDLE;
            op_q    <= cmo_pkg::CMO_FILL;
            pend_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            op_q    <= op_d;
            pend_q  <= pend_d;
        end
    end

    always_ff @(posedge clk_i) begin
        set_q       <= set_d;
        way_q       <= way_d;
        tag_q       <= tag_d;
        dirty_q     <= dirty_d;
        tid_q       <= tid_d;
        pend_set_q  <= pend_set_d;
        pend_way_q  <= pend_way_d;
        rsp_hit_q   <= rsp_hit_d;
        rsp_dirty_q <= rsp_dirty_d;
    end

    assign push_nline_o = {dir.entry_tag, pend_set_q};
    assign push_way_o   = pend_way_q;

    assign rsp_valid_o = (state_q == cmo_pkg::RESPOND);
    assign rsp_tid_o   = tid_q;
    assign rsp_hit_o   = rsp_hit_q;
    assign rsp_dirty_o = rsp_dirty_q;

endmodule

// ==== source/dir_port_if.sv ====
/* Directory access bundle: by-line lookup, by-entry check and update,
   with modports for the sequencer, the directory and the range tracker */
interface dir_port_if;

    // Lookup by line, answered combinationally
    logic              lookup_en;
    cmo_pkg::set_t     lookup_set;
    cmo_pkg::tag_t     lookup_tag;
    cmo_pkg::way_vec_t hit_way;
    logic              hit_dirty;

    // Entry check, answered one cycle later
    logic              check_en;
    cmo_pkg::set_t     check_set;
    cmo_pkg::way_vec_t check_way;
    logic              entry_valid;
    logic              entry_dirty;
    cmo_pkg::tag_t     entry_tag;

    // Single write path into the directory
    logic              updt_en;
    cmo_pkg::set_t     updt_set;
    cmo_pkg::way_vec_t updt_way;
    logic              updt_valid;
    logic              updt_dirty;
    cmo_pkg::tag_t     updt_tag;

    modport seq (
        output lookup_en, lookup_set, lookup_tag,
        output check_en, check_set, check_way,
        output updt_en, updt_set, updt_way, updt_valid, updt_dirty, updt_tag,
        input  hit_way, hit_dirty, entry_valid, entry_dirty, entry_tag
    );

    modport dir (
        input  lookup_en, lookup_set, lookup_tag,
        input  check_en, check_set, check_way,
        input  updt_en, updt_set, updt_way, updt_valid, updt_dirty, updt_tag,
        output hit_way, hit_dirty, entry_valid, entry_dirty, entry_tag
    );

    modport mon (
        input updt_en, updt_set, updt_valid, updt_dirty
    );

endinterface

// ==== source/flush_req_queue.sv ====
/* Circular FIFO of write-back requests, line number and way, read from registers */
module flush_req_queue (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              push_i,
    input  cmo_pkg::nline_t   push_nline_i,
    input  cmo_pkg::way_vec_t push_way_i,
    output logic              not_full_o,
    output logic              empty_o,
    output logic              pop_valid_o,
    input  logic              pop_ready_i,
    output cmo_pkg::nline_t   pop_nline_o,
    output cmo_pkg::way_vec_t pop_way_o
);

    cmo_pkg::nline_t   nline_q [cmo_pkg::FLUSH_Q_DEPTH];
    cmo_pkg::way_vec_t way_q   [cmo_pkg::FLUSH_Q_DEPTH];

    logic [$clog2(cmo_pkg::FLUSH_Q_DEPTH)-1:0]   rptr_q;
    logic [$clog2(cmo_pkg::FLUSH_Q_DEPTH)-1:0]   wptr_q;
    logic [$clog2(cmo_pkg::FLUSH_Q_DEPTH+1)-1:0] count_q;
    logic                                        do_push;
    logic                                        do_pop;

    assign not_full_o  = (count_q != cmo_pkg::FLUSH_Q_DEPTH);
    assign empty_o     = (count_q == '0);
    assign pop_valid_o = !empty_o;
    assign pop_nline_o = nline_q[rptr_q];
    assign pop_way_o   = way_q[rptr_q];

    assign do_push = push_i && not_full_o;
    assign do_pop  = pop_valid_o && pop_ready_i;

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rptr_q  <= '0;
            wptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (do_pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            nline_q[wptr_q] <= push_nline_i;
            way_q[wptr_q]   <= push_way_i;
        end
    end

endmodule

// ==== source/set_range_tracker.sv ====
/* Tracker of the lowest and highest sets holding valid lines and dirty lines,
   widened by directory updates and emptied by full operations */
module set_range_tracker (
    input  logic          clk_i,
    input  logic          rst_ni,
    dir_port_if.mon       mon,
    input  logic          clear_valid_i,
    input  logic          clear_dirty_i,
    output cmo_pkg::set_t valid_min_o,
    output cmo_pkg::set_t valid_max_o,
    output logic          valid_any_o,
    output cmo_pkg::set_t dirty_min_o,
    output cmo_pkg::set_t dirty_max_o,
    output logic          dirty_any_o
);

    typedef struct packed {
        logic          any;
        cmo_pkg::set_t lo;
        cmo_pkg::set_t hi;
    } range_t;

    range_t valid_q;
    range_t valid_d;
    range_t dirty_q;
    range_t dirty_d;

    // Grow a range to include set s
    function automatic range_t widen(range_t r, logic hit, cmo_pkg::set_t s);
        range_t n;
        n = r;
        if (hit) begin
            n.any = 1'b1;
            n.lo  = (!r.any || s < r.lo) ? s : r.lo;
            n.hi  = (!r.any || s > r.hi) ? s : r.hi;
        end
        return n;
    endfunction

    // Clear first so an update in the same cycle is still recorded
    always_comb begin
        valid_d = clear_valid_i ? '0 : valid_q;
        dirty_d = (clear_valid_i || clear_dirty_i) ? '0 : dirty_q;
        valid_d = widen(valid_d, mon.updt_en && mon.updt_valid, mon.updt_set);
        dirty_d = widen(dirty_d, mon.updt_en && mon.updt_valid && mon.updt_dirty,
                        mon.updt_set);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            valid_q <= valid_d;
            dirty_q <= dirty_d;
        end
    end

    assign valid_min_o = valid_q.lo;
    assign valid_max_o = valid_q.hi;
    assign valid_any_o = valid_q.any;
    assign dirty_min_o = dirty_q.lo;
    assign dirty_max_o = dirty_q.hi;
    assign dirty_any_o = dirty_q.any;

endmodule

// ==== verification/cmo_input.txt ====
# R op addr way dirty tid exp_hit exp_dirty  (request, hex fields)
# F nline way  (expected flush entry, queued before its flush operation)
R 0 1230 1 1 1 0 0
R 0 4560 2 0 2 0 0
R 0 7890 4 1 3 0 0
R 0 2b30 8 1 4 0 0
R 0 0a50 1 0 5 0 0
R 1 1230 0 0 6 1 1
R 1 4568 0 0 7 1 0
R 1 9990 0 0 8 0 0
R 2 2b30 0 0 9 0 0
R 1 2b30 0 0 a 0 0
R 1 1230 0 0 b 1 1
F 789 4
F 123 1
R 4 0000 0 0 c 0 0
R 1 1230 0 0 d 1 0
R 1 7890 0 0 e 1 0
R 4 0000 0 0 f 0 0
R 0 3c70 2 1 0 0 0
R 0 5e00 8 1 1 0 0
F 5e0 8
F 3c7 2
R 5 0000 0 0 2 0 0
R 1 1230 0 0 3 0 0
R 1 3c70 0 0 4 0 0
R 0 6610 1 1 5 0 0
R 0 6a40 4 0 6 0 0
R 3 0000 0 0 7 0 0
R 1 6610 0 0 8 0 0
R 4 0000 0 0 9 0 0

// ==== verification/tb_cmo_handler.sv ====
/* Testbench for the cache-maintenance handler: file-driven requests,
   random flush and response back-pressure, flush and response checks */
module tb_cmo_handler;
    timeunit 1ns;
    timeprecision 1ps;

    // One stimulus record where a flush record keeps its line number in addr
    typedef struct {
        bit is_flush;
        int op;
        int addr;
        int way;
        int dirty;
        int tid;
        int hit;
        int dty;
    } record_t;

    typedef struct {
        int nline;
        int way;
    } flush_exp_t;

    logic              clk_i = 1'b0;
    logic              rst_ni;
    logic              req_valid_i;
    cmo_pkg::cmo_op_e  req_op_i;
    cmo_pkg::addr_t    req_addr_i;
    cmo_pkg::way_vec_t req_way_i;
    logic              req_dirty_i;
    cmo_pkg::tid_t     req_tid_i;
    logic              req_ready_o;
    logic              rsp_ready_i;
    logic              rsp_valid_o;
    cmo_pkg::tid_t     rsp_tid_o;
    logic              rsp_hit_o;
    logic              rsp_dirty_o;
    logic              flush_ready_i;
    logic              flush_valid_o;
    cmo_pkg::nline_t   flush_nline_o;
    cmo_pkg::way_vec_t flush_way_o;

    record_t     records[$];
    flush_exp_t  exp_flush[$];
    flush_exp_t  exp_head;
    logic [31:0] lfsr_q;
    int          cycle_cnt;
    int          cycle_limit;
    logic        rsp_pending;
    logic        rsp_done;
    int          exp_tid;
    int          exp_hit;
    int          exp_dty;

    cmo_handler_top u_dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_valid_i   (req_valid_i),
        .req_op_i      (req_op_i),
        .req_addr_i    (req_addr_i),
        .req_way_i     (req_way_i),
        .req_dirty_i   (req_dirty_i),
        .req_tid_i     (req_tid_i),
        .req_ready_o   (req_ready_o),
        .rsp_ready_i   (rsp_ready_i),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_tid_o     (rsp_tid_o),
        .rsp_hit_o     (rsp_hit_o),
        .rsp_dirty_o   (rsp_dirty_o),
        .flush_ready_i (flush_ready_i),
        .flush_valid_o (flush_valid_o),
        .flush_nline_o (flush_nline_o),
        .flush_way_o   (flush_way_o)
    );

    initial begin
        forever #10 clk_i = ~clk_i;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic random_bit();
        lfsr_q = lfsr_next(lfsr_q);
        return lfsr_q[0];
    endfunction

    // Low in about one cycle in four when both drawn bits are set
    function automatic logic ready_draw();
        logic a;
        logic b;
        a = random_bit();
        b = random_bit();
        return !(a && b);
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic load_records();
        int      fd;
        int      n;
        string   line;
        record_t r;
        int      f[7];
        fd = $fopen("verification/cmo_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file verification/cmo_input.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Blank lines and column notes are skipped
            if (n > 1 && line[0] != "#") begin
                r = '{default: 0};
                if (line[0] == "F") begin
                    n = $sscanf(line, "F %h %h", f[0], f[1]);
                    r.is_flush = 1'b1;
                    r.addr = f[0];
                    r.way = f[1];
                end else begin
                    n = $sscanf(line, "R %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]) - 5;
                    r.op = f[0];
                    r.addr = f[1];
                    r.way = f[2];
                    r.dirty = f[3];
                    r.tid = f[4];
                    r.hit = f[5];
                    r.dty = f[6];
                end
                if (n != 2) begin
                    $display("stimulus file holds a record that cannot be read: %s", line);
                    abort_run();
                end
                records.push_back(r);
            end
        end
        $fclose(fd);
    endtask

    task automatic issue_request(input record_t r);
        @(negedge clk_i);
        req_op_i    = cmo_pkg::cmo_op_e'(r.op);
        req_addr_i  = cmo_pkg::addr_t'(r.addr);
        req_way_i   = cmo_pkg::way_vec_t'(r.way);
        req_dirty_i = r.dirty[0];
        req_tid_i   = cmo_pkg::tid_t'(r.tid);
        exp_tid     = r.tid;
        exp_hit     = r.hit;
        exp_dty     = r.dty;
        rsp_done    = 1'b0;
        rsp_pending = 1'b1;
        req_valid_i = 1'b1;
        // Held until a cycle in which the handler is ready
        while (!req_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        req_valid_i = 1'b0;
        wait (rsp_done);
    endtask

    // Back-pressure drawn and handshakes checked for the coming rising edge
    always @(negedge clk_i) begin
        rsp_ready_i   = ready_draw();
        flush_ready_i = ready_draw();
        if (rst_ni) begin
            if (flush_valid_o && flush_ready_i) begin
                if (exp_flush.size() == 0) begin
                    $display("unexpected flush entry for line %03h at %0t ns",
                             flush_nline_o, $time);
                    abort_run();
                end else begin
                    exp_head = exp_flush.pop_front();
                    check_equal(flush_nline_o, exp_head.nline, "flush line number");
                    check_equal(flush_way_o, exp_head.way, "flush way");
                end
            end
            if (rsp_valid_o && rsp_ready_i) begin
                if (!rsp_pending) begin
                    $display("response at %0t ns with no request outstanding", $time);
                    abort_run();
                end else if (exp_flush.size() != 0) begin
                    $display("response at %0t ns before %0d flush entries were sent",
                             $time, exp_flush.size());
                    abort_run();
                end else begin
                    check_equal(rsp_tid_o, exp_tid, "response tid");
                    check_equal(rsp_hit_o, exp_hit, "response hit");
                    check_equal(rsp_dirty_o, exp_dty, "response dirty");
                    rsp_pending = 1'b0;
                    rsp_done    = 1'b1;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        rst_ni        = 1'b0;
        req_valid_i   = 1'b0;
        req_op_i      = cmo_pkg::CMO_FILL;
        req_addr_i    = '0;
        req_way_i     = '0;
        req_dirty_i   = 1'b0;
        req_tid_i     = '0;
        rsp_ready_i   = 1'b1;
        flush_ready_i = 1'b1;
        lfsr_q        = 32'hfe1b;
        cycle_cnt     = 0;
        cycle_limit   = 200;
        rsp_pending   = 1'b0;
        rsp_done      = 1'b0;
        load_records();
        cycle_limit = 40 * records.size() + 200;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_equal(req_ready_o, 1'b1, "req_ready_o after reset");
        check_equal(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
        check_equal(flush_valid_o, 1'b0, "flush_valid_o after reset");
        foreach (records[i]) begin
            if (records[i].is_flush) begin
                exp_flush.push_back('{records[i].addr, records[i].way});
            end else begin
                issue_request(records[i]);
            end
        end
        // Idle tail catches stray flush entries
        repeat (8) @(negedge clk_i);
        check_equal(exp_flush.size(), 0, "flush entries never sent");
        $display("STATUS: PASS");
        $finish;
    end

endmodule
